// File: design/dram_pkg.sv
`default_nettype none

package dram_pkg;

    // word and address geometry
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 10;
    localparam int COL_W     = 4;
    localparam int BANK_W    = 2;
    localparam int ROW_W     = 4;
    localparam int NUM_BANKS = 1 << BANK_W;
    localparam int MEM_WORDS = 1 << ADDR_W;

    // access latency in cycles from acceptance to completion
    localparam int T_HIT  = 3;
    localparam int T_MISS = 7;   // precharge + activate + access
    localparam int LAT_W  = $clog2(T_MISS + 1);

    // queue sizes
    localparam int REQ_DEPTH = 4;
    localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);
    localparam int RSP_DEPTH = 4;   // also caps pending write acks
    localparam int RSP_PTR_W = $clog2(RSP_DEPTH);
    localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);

    // bank engine states
    localparam int         ST_W    = 2;
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    typedef logic [DATA_W-1:0] data_t;

    // same word seen as array index or as row/bank/column
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [ROW_W-1:0]  row;
            logic [BANK_W-1:0] bank;
            logic [COL_W-1:0]  col;
        } fields;
    } dram_addr_u;

endpackage

`default_nettype wire

// File: design/dram_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dram_req_if
    import dram_pkg::*;
();

    logic       valid;
    logic       ready;
    logic       we;     // 1 = write, 0 = read
    dram_addr_u addr;
    data_t      wdata;

    // request buffer side
    modport source (output valid, output we, output addr, output wdata, input ready);

    // bank engine side
    modport sink (input valid, input we, input addr, input wdata, output ready);

endinterface

`default_nettype wire

// File: design/dram_rsp_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dram_rsp_if
    import dram_pkg::*;
();

    // read data channel
    logic  rvalid;
    logic  rready;
    data_t rdata;

    // write ack channel, no payload
    logic  bvalid;
    logic  bready;

    modport source (output rvalid, output rdata, output bvalid, input rready, input bready);

    modport sink (input rvalid, input rdata, input bvalid, output rready, output bready);

endinterface

`default_nettype wire

// File: design/dram_req_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dram_req_buffer
    import dram_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  data_t             wdata_i,
    output logic              req_ready_o,
    dram_req_if.source        req_o
);

    logic                 we_q    [REQ_DEPTH];
    logic [ADDR_W-1:0]    addr_q  [REQ_DEPTH];
    data_t                wdata_q [REQ_DEPTH];
    logic [REQ_PTR_W-1:0] wr_ptr_q;
    logic [REQ_PTR_W-1:0] rd_ptr_q;
    logic [REQ_CNT_W-1:0] cnt_q;
    logic                 push;
    logic                 pop;

    assign req_ready_o = (cnt_q != REQ_CNT_W'(REQ_DEPTH));  // low only when full
    assign push        = req_valid_i & req_ready_o;
    assign pop         = req_o.valid & req_o.ready;

    // head entry goes straight to the engine
    assign req_o.valid = (cnt_q != '0);
    assign req_o.we    = we_q[rd_ptr_q];
    assign req_o.addr  = dram_addr_u'(addr_q[rd_ptr_q]);
    assign req_o.wdata = wdata_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            we_q[wr_ptr_q]    <= we_i;
            addr_q[wr_ptr_q]  <= addr_i;
            wdata_q[wr_ptr_q] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: design/dram_bank_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dram_bank_engine
    import dram_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    dram_req_if.sink   req_i,
    dram_rsp_if.source rsp_o
);

    logic [ST_W-1:0]      state_q;
    logic [LAT_W-1:0]     cnt_q;
    logic [NUM_BANKS-1:0] row_open_q;   // bank has an active row
    logic [ROW_W-1:0]     open_row_q [NUM_BANKS];

    // request being served
    logic                 we_q;
    dram_addr_u           addr_q;
    data_t                wdata_q;
    data_t                rdata_q;

    data_t                mem_q [MEM_WORDS];

    logic                 accept;
    logic                 row_hit;
    logic                 last_cycle;
    logic                 rsp_done;

    assign req_i.ready = (state_q == ST_IDLE);
    assign accept      = req_i.valid & req_i.ready;

    // hit only if this bank already has the same row open
    assign row_hit = row_open_q[req_i.addr.fields.bank]
                     && (open_row_q[req_i.addr.fields.bank] == req_i.addr.fields.row);

    assign last_cycle = (state_q == ST_BUSY) && (cnt_q == '0);

    assign rsp_o.rvalid = (state_q == ST_DONE) && !we_q;
    assign rsp_o.bvalid = (state_q == ST_DONE) && we_q;
    assign rsp_o.rdata  = rdata_q;
    assign rsp_done     = (rsp_o.rvalid & rsp_o.rready) | (rsp_o.bvalid & rsp_o.bready);

    // idle -> busy -> done, one request at a time
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            row_open_q <= '0;  // all banks precharged
        end else begin
            unique case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_BUSY;
                        cnt_q   <= row_hit ? LAT_W'(T_HIT - 1) : LAT_W'(T_MISS - 1);
                        row_open_q[req_i.addr.fields.bank] <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                ST_DONE: begin
                    if (rsp_done) begin
                        state_q <= ST_IDLE;  // ready again next cycle
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // latch request and track the row it opens
    always_ff @(posedge clk_i) begin
        if (accept) begin
            we_q    <= req_i.we;
            addr_q  <= req_i.addr;
            wdata_q <= req_i.wdata;
            open_row_q[req_i.addr.fields.bank] <= req_i.addr.fields.row;
        end
    end

    // array access on the final latency cycle
    always_ff @(posedge clk_i) begin
        if (last_cycle) begin
            if (we_q) begin
                mem_q[addr_q.flat] <= wdata_q;
            end else begin
                rdata_q <= mem_q[addr_q.flat];  // held through done
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dram_rsp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dram_rsp_stage
    import dram_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    dram_rsp_if.sink rsp_i,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output data_t    rdata_o,
    output logic     b_valid_o,
    input  logic     b_ready_i
);

    data_t                rd_fifo_q [RSP_DEPTH];
    logic [RSP_PTR_W-1:0] wr_ptr_q;
    logic [RSP_PTR_W-1:0] rd_ptr_q;
    logic [RSP_CNT_W-1:0] rd_cnt_q;
    logic [RSP_CNT_W-1:0] ack_cnt_q;  // write acks still owed
    logic                 r_push;
    logic                 r_pop;
    logic                 b_push;
    logic                 b_pop;

    // accept only on own free space
    assign rsp_i.rready = (rd_cnt_q != RSP_CNT_W'(RSP_DEPTH));
    assign rsp_i.bready = (ack_cnt_q != RSP_CNT_W'(RSP_DEPTH));

    assign r_push = rsp_i.rvalid & rsp_i.rready;
    assign r_pop  = rsp_valid_o & rsp_ready_i;
    assign b_push = rsp_i.bvalid & rsp_i.bready;
    assign b_pop  = b_valid_o & b_ready_i;

    assign rsp_valid_o = (rd_cnt_q != '0);
    assign rdata_o     = rd_fifo_q[rd_ptr_q];  // stable until popped
    assign b_valid_o   = (ack_cnt_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            rd_cnt_q  <= '0;
            ack_cnt_q <= '0;
        end else begin
            if (r_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (r_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            unique case ({r_push, r_pop})
                2'b10:   rd_cnt_q <= rd_cnt_q + 1'b1;
                2'b01:   rd_cnt_q <= rd_cnt_q - 1'b1;
                default: rd_cnt_q <= rd_cnt_q;
            endcase
            unique case ({b_push, b_pop})
                2'b10:   ack_cnt_q <= ack_cnt_q + 1'b1;
                2'b01:   ack_cnt_q <= ack_cnt_q - 1'b1;
                default: ack_cnt_q <= ack_cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_push) begin
            rd_fifo_q[wr_ptr_q] <= rsp_i.rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/dram_top.sv
`timescale 1ns/1ps
`default_nettype none

module dram_top
    import dram_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    // request channel
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  data_t             wdata_i,
    // read response channel
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output data_t             rdata_o,
    // write ack channel
    output logic              b_valid_o,
    input  logic              b_ready_i
);

    dram_req_if req_if ();
    dram_rsp_if rsp_if ();

    dram_req_buffer u_req_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .req_ready_o (req_ready_o),
        .req_o       (req_if.source)
    );

    dram_bank_engine u_bank_engine (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req_i  (req_if.sink),
        .rsp_o  (rsp_if.source)
    );

    dram_rsp_stage u_rsp_stage (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rsp_i       (rsp_if.sink),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rdata_o     (rdata_o),
        .b_valid_o   (b_valid_o),
        .b_ready_i   (b_ready_i)
    );

endmodule

`default_nettype wire

// File: verification/dram_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dram_assertions
    import dram_pkg::*;
(
    input logic  clk_i,
    input logic  rst_ni,
    input logic  rsp_valid_o,
    input logic  rsp_ready_i,
    input data_t rdata_o,
    input logic  b_valid_o,
    input logic  b_ready_i
);

    // read word frozen while the consumer stalls
    property rdata_stable_p;
        @(posedge clk_i) disable iff (!rst_ni)
            rsp_valid_o && !rsp_ready_i |=> $stable(rdata_o);
    endproperty

    property rsp_valid_held_p;
        @(posedge clk_i) disable iff (!rst_ni)
            rsp_valid_o && !rsp_ready_i |=> rsp_valid_o;
    endproperty

    property b_valid_held_p;
        @(posedge clk_i) disable iff (!rst_ni)
            b_valid_o && !b_ready_i |=> b_valid_o;
    endproperty

    property no_valid_in_reset_p;
        @(posedge clk_i) !rst_ni |=> !rsp_valid_o && !b_valid_o;
    endproperty

    rdata_stable_a: assert property (rdata_stable_p)
        else $error("rdata_o changed while the read response was stalled");
    rsp_valid_held_a: assert property (rsp_valid_held_p)
        else $error("rsp_valid_o dropped before its handshake");
    b_valid_held_a: assert property (b_valid_held_p)
        else $error("b_valid_o dropped before its handshake");
    no_valid_in_reset_a: assert property (no_valid_in_reset_p)
        else $error("a response valid was high during reset");

endmodule

`default_nettype wire

// File: verification/dram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dram_tb
    import dram_pkg::*;
();

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic              req_ready;
    logic              we;
    logic [ADDR_W-1:0] addr;
    data_t             wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    data_t             rdata;
    logic              b_valid;
    logic              b_ready;

    // one entry per trace operation
    byte               op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    data_t             data_q[$];
    int                idle_q[$];

    data_t exp_rd_q[$];    // read words still owed in request order
    int    writes_sent;
    int    acks_seen;
    int    errors;
    int    timeouts;
    int    seed;
    int    wait_limit;     // cycles per wait loop
    bit    rand_ready;
    bit    stall;          // both readies held low
    bit    saw_full;
    bit    hold_q;
    data_t held_data;

    // expected open row per bank for latency
    logic [NUM_BANKS-1:0] row_open;
    logic [ROW_W-1:0]     open_row [NUM_BANKS];

    dram_top uut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .we_i        (we),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rdata_o     (rdata),
        .b_valid_o   (b_valid),
        .b_ready_i   (b_ready)
    );

    bind dram_top dram_assertions u_assertions (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin : ready_gen
        int rnd;
        if (stall) begin
            rsp_ready <= 1'b0;
            b_ready   <= 1'b0;
        end else if (rand_ready) begin
            rnd = $random(seed);
            rsp_ready <= rnd[0];
            b_ready   <= rnd[1];
        end else begin
            rsp_ready <= 1'b1;
            b_ready   <= 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // sampled mid-cycle so a handshake here completes at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (hold_q) begin
                check_value("rsp_valid_hold", 1, rsp_valid);
                check_value("rdata_hold", held_data, rdata);
            end
            if (rsp_valid && rsp_ready) begin
                assert (exp_rd_q.size() != 0) else begin
                    errors++;
                    $display("read response arrived with no read outstanding");
                end
                if (exp_rd_q.size() != 0) begin
                    check_value("read_data", exp_rd_q.pop_front(), rdata);
                end
            end
            if (b_valid && b_ready) begin
                acks_seen++;
                assert (acks_seen <= writes_sent) else begin
                    errors++;
                    $display("write acknowledge arrived with no write outstanding");
                end
            end
            hold_q    = rsp_valid && !rsp_ready;
            held_data = rdata;
        end
    end

    task automatic issue_op(input int idx, input int idle);
        int waited;
        repeat (idle) @(posedge clk);
        waited = 0;
        @(negedge clk);
        while (!req_ready && waited < wait_limit) begin
            if (stall) begin
                saw_full = 1'b1;   // request FIFO full so release the stall
                stall    = 1'b0;
            end
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("timed out waiting for the request port to become ready");
        end
        @(posedge clk);
        req_valid <= 1'b1;
        we        <= (op_q[idx] == "W");
        addr      <= addr_q[idx];
        wdata     <= data_q[idx];
        if (op_q[idx] == "W") begin
            writes_sent++;
        end else begin
            exp_rd_q.push_back(data_q[idx]);
        end
        @(posedge clk);    // transfer edge
        req_valid <= 1'b0;
    endtask

    // cycles from acceptance to response valid for one op on an idle pipeline
    task automatic measure_op(input int idx);
        int   cycles;
        int   bank;
        int   row;
        int   expected;
        logic is_write;
        is_write = (op_q[idx] == "W");
        bank     = addr_q[idx][COL_W +: BANK_W];
        row      = addr_q[idx][COL_W+BANK_W +: ROW_W];
        expected = (row_open[bank] && open_row[bank] == row) ? T_HIT + 2 : T_MISS + 2;
        row_open[bank] = 1'b1;
        open_row[bank] = row;
        issue_op(idx, 0);
        cycles = 0;
        @(negedge clk);
        while (!(is_write ? b_valid : rsp_valid) && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= wait_limit) begin
            timeouts++;
            $display("timed out waiting for the response to a single op");
        end
        check_value(is_write ? "write_latency" : "read_latency", expected, cycles);
        @(posedge clk);    // response taken with ready high
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_rd_q.size() != 0 || acks_seen != writes_sent) && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd_q.size() != 0 || acks_seen != writes_sent) begin
            timeouts++;
            $display("timed out waiting for outstanding responses to drain");
        end
    endtask

    initial begin : main
        int                fd;
        int                n;
        string             line;
        byte               op;
        logic [ADDR_W-1:0] a;
        data_t             d;
        int                idle;
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        rsp_ready   = 1'b1;
        b_ready     = 1'b1;
        seed        = 15;
        wait_limit  = 400;
        errors      = 0;
        timeouts    = 0;
        writes_sent = 0;
        acks_seen   = 0;
        rand_ready  = 1'b0;
        stall       = 1'b0;
        saw_full    = 1'b0;
        hold_q      = 1'b0;
        row_open    = '0;   // all banks closed after reset

        fd = $fopen("verification/dram_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %d", op, a, d, idle);
                    if (n == 4) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        idle_q.push_back(idle);
                    end
                end
            end
            $fclose(fd);
        end

        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("reset_rsp_valid", 0, rsp_valid);
            check_value("reset_b_valid", 0, b_valid);
            check_value("reset_req_ready", 1, req_ready);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("post_reset_rsp_valid", 0, rsp_valid);
        check_value("post_reset_b_valid", 0, b_valid);
        check_value("post_reset_req_ready", 1, req_ready);

        // hit and miss latency with one op at a time
        for (int i = 0; i < op_q.size(); i++) begin
            measure_op(i);
        end
        drain();

        // idle gaps from the trace with random ready
        rand_ready = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            issue_op(i, idle_q[i]);
        end
        drain();

        // long stall until the request port backs up
        stall = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            issue_op(i, 0);
        end
        stall = 1'b0;
        drain();

        // no stray response may follow within the longest latency
        repeat (T_MISS + 2) @(negedge clk);
        check_value("final_rsp_valid", 0, rsp_valid);
        check_value("final_b_valid", 0, b_valid);

        check_value("backpressure_full", 1, saw_full);
        check_value("write_ack_count", writes_sent, acks_seen);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/dram_trace.txt
# op addr(hex) data(hex) idle_cycles_before_op
# W writes data to addr, R expects data back from addr
W 000 11110000 0
W 001 11110001 0
R 000 11110000 0
W 010 22220010 1
W 025 22220025 0
W 03a 2222003a 2
W 040 33330040 0
R 001 11110001 0
R 000 11110000 0
W 000 44440000 0
R 040 33330040 3
R 010 22220010 0
R 000 44440000 0
W 3ff 555503ff 0
R 3ff 555503ff 1
R 025 22220025 0

// File: src.f
design/dram_pkg.sv
design/dram_req_if.sv
design/dram_rsp_if.sv
design/dram_req_buffer.sv
design/dram_bank_engine.sv
design/dram_rsp_stage.sv
design/dram_top.sv
verification/dram_assertions.sv
verification/dram_tb.sv

// File: Bender.yml
package:
  name: dram

sources:
  - design/dram_pkg.sv
  - design/dram_req_if.sv
  - design/dram_rsp_if.sv
  - design/dram_req_buffer.sv
  - design/dram_bank_engine.sv
  - design/dram_rsp_stage.sv
  - design/dram_top.sv
  - target: simulation
    files:
      - verification/dram_assertions.sv
      - verification/dram_tb.sv
